// ==== Bender.yml ====
package:
  name: eth_switch

export_include_dirs:
  - logic

sources:
  - logic/switch_pkg.sv
  - logic/frame_fifo.sv
  - logic/frame_rx.sv
  - logic/forwarder.sv
  - logic/mixer.sv
  - logic/eth_switch.sv
  - target: test
    files:
      - dv/eth_switch_tb.sv

// ==== dv/eth_switch_tb.sv ====
// Trace-driven testbench for the switch, run with the file list from the project root
`timescale 1ns/1ps
`include "switch_macros.svh"

module eth_switch_tb
  import switch_pkg::*;
();

  localparam real         CLK_PERIOD  = 8.0;
  localparam int          TIMEOUT     = 4000;
  localparam logic [31:0] SEED        = 32'h5d3b8431;
  localparam string       TRACE_FILE  = "dv/switch_trace.txt";
  localparam int          MAX_FRAMES  = 64;
  localparam int          MAX_LEN     = 64;
  localparam int          PAYLOAD_MAX = 4096;
  localparam int          T_RESET     = 0;
  localparam int          T_FRAMES    = 1;
  localparam int          T_GAP       = 2;
  localparam int          T_DRAIN     = 3;

  logic       sys_clk;
  logic       rst_n;
  gmii_t      gmii_rx  [`NPORT];
  port_mask_t fwd_mask [`NPORT];
  gmii_t      gmii_tx  [`NPORT];

  // --------------------
  // Frame table
  // --------------------
  int         nframes;
  int         frame_src  [MAX_FRAMES];
  port_mask_t frame_mask [MAX_FRAMES];
  port_mask_t frame_dest [MAX_FRAMES];
  port_mask_t frame_done [MAX_FRAMES];
  int         frame_len  [MAX_FRAMES];
  int         frame_idle [MAX_FRAMES];
  int         frame_off  [MAX_FRAMES];
  realtime    frame_time [MAX_FRAMES];
  byte_t      payload    [PAYLOAD_MAX];

  // Monitor state per transmit port
  byte_t mon_buf   [`NPORT][MAX_LEN];
  int    mon_len   [`NPORT];
  int    low_cnt   [`NPORT];
  logic  had_frame [`NPORT];
  int    seen_cnt  [`NPORT];

  string test_name [4] = '{"reset", "frames", "gap", "drain"};
  int    test_errs [4];
  int    checks;
  int    drivers_done;
  logic  first_driven;

  eth_switch i_eth_switch (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .gmii_rx  (gmii_rx),
    .fwd_mask (fwd_mask),
    .gmii_tx  (gmii_tx)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    int          off;
    int          src;
    int          len;
    int          idle;
    port_mask_t  mask;
    port_mask_t  dest;
    string       line;
    logic [31:0] rnd;
    byte_t       seq [`NPORT];
    rnd     = SEED;
    off     = 0;
    nframes = 0;
    foreach (seq[i]) seq[i] = '0;
    fd = $fopen(TRACE_FILE, "r");
    assert (fd != 0) else begin
      $display("Could not open the trace file %s", TRACE_FILE);
      test_errs[T_FRAMES]++;
    end
    while (fd != 0 && !$feof(fd) && nframes < MAX_FRAMES) begin
      line = "";
      void'($fgets(line, fd));
      n = 0;
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%d %h %d %d %h", src, mask, len, idle, dest);
      end
      if (n == 5 && src < `NPORT && len >= 2 && len <= MAX_LEN && off + len <= PAYLOAD_MAX) begin
        frame_src[nframes]  = src;
        frame_mask[nframes] = mask;
        frame_dest[nframes] = dest;
        frame_done[nframes] = '0;
        frame_len[nframes]  = len;
        frame_idle[nframes] = idle;
        frame_off[nframes]  = off;
        frame_time[nframes] = -1.0;
        for (int b = 0; b < len; b++) begin
          rnd = xorshift(rnd);
          payload[off + b] = rnd[7:0];
        end
        // Source port and sequence number lead every payload
        payload[off]     = byte_t'(src);
        payload[off + 1] = seq[src];
        seq[src]++;
        off += len;
        nframes++;
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  task automatic drive_port(input int p);
    for (int i = 0; i < nframes; i++) begin
      if (frame_src[i] == p) begin
        repeat (frame_idle[i]) @(posedge sys_clk);
        for (int b = 0; b < frame_len[i]; b++) begin
          @(posedge sys_clk);
          #1;
          if (b == 0) begin
            frame_time[i] = $realtime;
            first_driven  = 1'b1;
            fwd_mask[p]   = frame_mask[i];
          end
          gmii_rx[p].en   = 1'b1;
          gmii_rx[p].data = payload[frame_off[i] + b];
        end
        @(posedge sys_clk);
        #1;
        gmii_rx[p].en = 1'b0;
      end
    end
    drivers_done++;
  endtask

  // Frames for port d that had time to reach its mixer but have not started
  function automatic int waiting_frames(input int d);
    int n;
    n = 0;
    for (int i = 0; i < nframes; i++) begin
      if (frame_dest[i][d] && frame_time[i] >= 0.0 &&
          frame_time[i] <= $realtime - 6 * CLK_PERIOD) begin
        n++;
      end
    end
    return n - seen_cnt[d];
  endfunction

  function automatic int pending_frames();
    int n;
    n = 0;
    for (int i = 0; i < nframes; i++) begin
      n += $countones(frame_dest[i] & ~frame_done[i]);
    end
    return n;
  endfunction

  task automatic check_frame(input int d);
    int s;
    int idx;
    int bad;
    s   = int'(mon_buf[d][0]);
    idx = -1;
    bad = -1;
    // Oldest undelivered frame of that source for this port
    for (int i = 0; i < nframes; i++) begin
      if (idx < 0 && frame_src[i] == s && frame_dest[i][d] && !frame_done[i][d]) begin
        idx = i;
      end
    end
    checks++;
    assert (idx >= 0) else begin
      $display("Unexpected frame of %0d bytes on port %0d from source %0d", mon_len[d], d, s);
      test_errs[T_FRAMES]++;
    end
    if (idx >= 0) begin
      frame_done[idx][d] = 1'b1;
      assert (mon_len[d] == frame_len[idx]) else begin
        $display("Error: test %s port %0d expected length %0d actual %0d",
                 test_name[T_FRAMES], d, frame_len[idx], mon_len[d]);
        test_errs[T_FRAMES]++;
      end
      for (int b = 0; b < frame_len[idx] && b < mon_len[d] && b < MAX_LEN; b++) begin
        if (bad < 0 && mon_buf[d][b] != payload[frame_off[idx] + b]) begin
          bad = b;
        end
      end
      assert (bad < 0) else begin
        $display("Error: test %s port %0d byte %0d expected %h actual %h", test_name[T_FRAMES],
                 d, bad, payload[frame_off[idx] + bad], mon_buf[d][bad]);
        test_errs[T_FRAMES]++;
      end
    end
  endtask

  task automatic report_test(input int t);
    $display("Test %s finished with %0d errors", test_name[t], test_errs[t]);
  endtask

  // --------------------
  // Transmit monitors
  // --------------------
  always @(negedge sys_clk) begin
    for (int p = 0; p < `NPORT; p++) begin
      if (!rst_n || !first_driven) begin
        assert (!gmii_tx[p].en) else begin
          $display("Error: test %s port %0d expected en 0 actual %0d",
                   test_name[T_RESET], p, gmii_tx[p].en);
          test_errs[T_RESET]++;
        end
      end
      if (gmii_tx[p].en) begin
        if (mon_len[p] == 0 && had_frame[p]) begin
          checks++;
          assert (low_cnt[p] >= `IFG_CYCLES) else begin
            $display("Error: test %s port %0d expected %0d idle cycles actual %0d",
                     test_name[T_GAP], p, `IFG_CYCLES, low_cnt[p]);
            test_errs[T_GAP]++;
          end
        end
        if (mon_len[p] == 0) seen_cnt[p]++;
        if (mon_len[p] < MAX_LEN) mon_buf[p][mon_len[p]] = gmii_tx[p].data;
        mon_len[p]++;
        low_cnt[p] = 0;
      end else begin
        if (mon_len[p] > 0) begin
          check_frame(p);
          mon_len[p]   = 0;
          had_frame[p] = 1'b1;
        end
        low_cnt[p]++;
        if (had_frame[p] && low_cnt[p] == `IFG_CYCLES + 1) begin
          checks++;
          assert (waiting_frames(p) <= 0) else begin
            $display("Port %0d stayed idle past the gap while a frame was waiting", p);
            test_errs[T_GAP]++;
          end
        end
      end
    end
  end

  initial begin
    int cyc;
    int total;
    rst_n        = 1'b0;
    first_driven = 1'b0;
    drivers_done = 0;
    checks       = 0;
    for (int p = 0; p < `NPORT; p++) begin
      gmii_rx[p]   = '0;
      fwd_mask[p]  = '0;
      mon_len[p]   = 0;
      low_cnt[p]   = 0;
      had_frame[p] = 1'b0;
      seen_cnt[p]  = 0;
    end
    foreach (test_errs[i]) test_errs[i] = 0;
    load_trace();
    repeat (10) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;
    for (int p = 0; p < `NPORT; p++) begin
      fork
        automatic int port = p;
        drive_port(port);
      join_none
    end

    cyc = 0;
    while (!first_driven && cyc < TIMEOUT) begin
      @(posedge sys_clk);
      cyc++;
    end
    assert (first_driven) else begin
      $display("Timed out before the first frame was driven");
      test_errs[T_RESET]++;
    end
    report_test(T_RESET);

    cyc = 0;
    while (drivers_done < `NPORT && cyc < TIMEOUT) begin
      @(posedge sys_clk);
      cyc++;
    end
    cyc = 0;
    while (pending_frames() > 0 && cyc < TIMEOUT) begin
      @(posedge sys_clk);
      cyc++;
    end
    assert (drivers_done == `NPORT && pending_frames() == 0) else begin
      $display("Timed out with %0d expected frames not delivered", pending_frames());
      test_errs[T_DRAIN]++;
    end
    // Quiet window to catch stray frames
    repeat (4 * `IFG_CYCLES) @(posedge sys_clk);
    report_test(T_FRAMES);
    report_test(T_GAP);
    report_test(T_DRAIN);

    total = 0;
    foreach (test_errs[i]) total += test_errs[i];
    $display("Tests run: 4, checks: %0d, errors: %0d", checks, total);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== dv/switch_trace.txt ====
# src mask(hex) len idle dest(hex): source port, forwarding mask, frame length,
# idle cycles before the frame on its own port, expected destination ports
0 2 64 4 2
1 2 16 20 0
2 f 40 120 b
2 4 20 10 0
3 7 32 200 7
3 1 60 2 1
2 8 48 80 8
1 8 48 234 8
0 8 48 200 8
0 8 30 2 8
1 8 30 2 8
2 8 30 2 8
0 a 24 40 a
1 9 24 40 9
3 e 36 30 6

// ==== eth_switch.f ====
+incdir+logic
logic/switch_pkg.sv
logic/frame_fifo.sv
logic/frame_rx.sv
logic/forwarder.sv
logic/mixer.sv
logic/eth_switch.sv
dv/eth_switch_tb.sv

// ==== logic/eth_switch.sv ====
// Switch top level joining framers, receive queues, forwarders, crossbar and mixers
`timescale 1ns/1ps
`include "switch_macros.svh"

module eth_switch
  import switch_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  gmii_t      gmii_rx  [`NPORT],
  input  port_mask_t fwd_mask [`NPORT],
  output gmii_t      gmii_tx  [`NPORT]
);

  wire rx_word_t   rxq_in_data   [`NPORT];
  wire             rxq_in_valid  [`NPORT];
  wire             rxq_in_ready  [`NPORT];
  wire rx_word_t   rxq_out_data  [`NPORT];
  wire             rxq_out_valid [`NPORT];
  wire             rxq_out_ready [`NPORT];

  // Forwarder side indexed [src], bit dst
  wire xq_word_t   fwd_data      [`NPORT];
  wire port_mask_t xq_in_valid   [`NPORT];
  wire port_mask_t xq_in_ready   [`NPORT];

  // Mixer side indexed [dst], bit or element src
  wire xq_word_t   xq_out_data   [`NPORT][`NPORT];
  wire port_mask_t xq_out_valid  [`NPORT];
  wire port_mask_t xq_out_ready  [`NPORT];

  // --------------------
  // Per-port pipeline
  // --------------------
  for (genvar p = 0; p < `NPORT; p++) begin : g_port
    frame_rx i_frame_rx (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .gmii_rx   (gmii_rx[p]),
      .fwd_mask  (fwd_mask[p]),
      .rxq_data  (rxq_in_data[p]),
      .rxq_valid (rxq_in_valid[p]),
      .rxq_ready (rxq_in_ready[p])
    );

    frame_fifo #(.DEPTH_LOG2(`RXQ_DEPTH_LOG2), .data_t(rx_word_t)) i_rx_queue (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .in_data   (rxq_in_data[p]),
      .in_valid  (rxq_in_valid[p]),
      .in_ready  (rxq_in_ready[p]),
      .out_data  (rxq_out_data[p]),
      .out_valid (rxq_out_valid[p]),
      .out_ready (rxq_out_ready[p])
    );

    forwarder #(.PORT_ID(port_id_t'(p))) i_forwarder (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .rxq_data  (rxq_out_data[p]),
      .rxq_valid (rxq_out_valid[p]),
      .rxq_ready (rxq_out_ready[p]),
      .xq_data   (fwd_data[p]),
      .xq_valid  (xq_in_valid[p]),
      .xq_ready  (xq_in_ready[p])
    );

    mixer i_mixer (
      .sys_clk  (sys_clk),
      .rst_n    (rst_n),
      .xq_data  (xq_out_data[p]),
      .xq_valid (xq_out_valid[p]),
      .xq_ready (xq_out_ready[p]),
      .gmii_tx  (gmii_tx[p])
    );
  end

  // --------------------
  // Crossbar queues
  // --------------------
  for (genvar s = 0; s < `NPORT; s++) begin : g_xbar_src
    for (genvar d = 0; d < `NPORT; d++) begin : g_xbar_dst
      if (s != d) begin : g_queue
        frame_fifo #(.DEPTH_LOG2(`XQ_DEPTH_LOG2), .data_t(xq_word_t)) i_xq (
          .sys_clk   (sys_clk),
          .rst_n     (rst_n),
          .in_data   (fwd_data[s]),
          .in_valid  (xq_in_valid[s][d]),
          .in_ready  (xq_in_ready[s][d]),
          .out_data  (xq_out_data[d][s]),
          .out_valid (xq_out_valid[d][s]),
          .out_ready (xq_out_ready[d][s])
        );
      end else begin : g_idle
        // No path back to the source port
        assign xq_in_ready[s][d]  = 1'b1;
        assign xq_out_valid[d][s] = 1'b0;
        assign xq_out_data[d][s]  = '0;
      end
    end
  end

endmodule

// ==== logic/forwarder.sv ====
// Per-port forwarder that copies each received frame into its crossbar queues
`timescale 1ns/1ps
`include "switch_macros.svh"

module forwarder
  import switch_pkg::*;
#(
  parameter port_id_t PORT_ID = '0
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  rx_word_t   rxq_data,
  input  logic       rxq_valid,
  output logic       rxq_ready,
  output xq_word_t   xq_data,
  output port_mask_t xq_valid,
  input  port_mask_t xq_ready
);

  localparam port_mask_t OWN_BIT = port_mask_t'(1) << PORT_ID;

  fwd_state_e state;
  port_mask_t dest_q;
  port_mask_t dest;
  logic       all_ready;
  logic       pop;

  // --------------------
  // Destination set
  // --------------------
  // Taken from the first word, never back to the source port
  always_comb begin
    if (state == HEAD) begin
      dest = rxq_data.mask & ~OWN_BIT;
    end else begin
      dest = dest_q;
    end
  end

  // Unselected queues count as ready, so an empty set just drains
  assign all_ready = &(xq_ready | ~dest);

  assign rxq_ready = all_ready;
  assign pop       = rxq_valid && all_ready;

  // All copies move together or not at all
  assign xq_valid = dest & {`NPORT{pop}};
  assign xq_data  = rxq_data.word;

  // --------------------
  // Frame tracking
  // --------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= HEAD;
      dest_q <= '0;
    end else begin
      case (state)
        HEAD: begin
          if (pop) begin
            dest_q <= dest;
            if (!rxq_data.word.last) begin
              state <= BODY;
            end
          end
        end
        BODY: begin
          if (pop && rxq_data.word.last) begin
            state <= HEAD;
          end
        end
        default: state <= HEAD;
      endcase
    end
  end

endmodule

// ==== logic/frame_fifo.sv ====
// Synchronous first-word-fall-through queue used for receive and crossbar buffering
`timescale 1ns/1ps

module frame_fifo #(
  parameter int unsigned DEPTH_LOG2 = 4,
  parameter type         data_t     = logic [7:0]
) (
  input  logic  sys_clk,
  input  logic  rst_n,
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam logic [DEPTH_LOG2:0] FULL_COUNT = 1 << DEPTH_LOG2;

  data_t                 mem [1 << DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign in_ready  = (count != FULL_COUNT);
  assign out_valid = (count != '0);
  // Head word is always on the output
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/frame_rx.sv ====
// GMII receive framer for one port, feeds flagged words into the receive queue
`timescale 1ns/1ps
`include "switch_macros.svh"

module frame_rx
  import switch_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  gmii_t      gmii_rx,
  input  port_mask_t fwd_mask,
  output rx_word_t   rxq_data,
  output logic       rxq_valid,
  input  logic       rxq_ready
);

  rx_state_e  state;
  byte_t      hold_byte;
  port_mask_t mask_q;

  // Held byte goes out once the next one shows up, or with last when en drops
  assign rxq_valid = (state == FRAME);

  always_comb begin
    rxq_data.mask      = mask_q;
    rxq_data.word.last = ~gmii_rx.en;
    rxq_data.word.data = hold_byte;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      mask_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (gmii_rx.en) begin
            state  <= FRAME;
            mask_q <= fwd_mask;
          end
        end
        FRAME: begin
          // Keep offering the closing word until it is taken
          if (!gmii_rx.en && rxq_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // A stalled word keeps its byte and the incoming one is lost
  always_ff @(posedge sys_clk) begin
    if (gmii_rx.en && ((state == IDLE) || rxq_ready)) begin
      hold_byte <= gmii_rx.data;
    end
  end

endmodule

// ==== logic/mixer.sv ====
// Transmit mixer for one port, sends whole frames round-robin with a fixed gap
`timescale 1ns/1ps
`include "switch_macros.svh"

module mixer
  import switch_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  xq_word_t   xq_data [`NPORT],
  input  port_mask_t xq_valid,
  output port_mask_t xq_ready,
  output gmii_t      gmii_tx
);

  localparam int unsigned GAP_W = $clog2(`IFG_CYCLES);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`IFG_CYCLES - 1);

  mix_state_e       state;
  port_id_t         last_q;
  logic [GAP_W-1:0] gap_cnt;
  port_id_t         cand;
  port_id_t         pick_id;
  logic             pick_found;
  port_id_t         sel_id;
  logic             pop;

  // --------------------
  // Round-robin pick
  // --------------------
  // Search starts at the port after the one served last
  always_comb begin
    pick_found = 1'b0;
    pick_id    = last_q;
    cand       = last_q;
    for (int i = 1; i <= `NPORT; i++) begin
      cand = port_id_t'(last_q + i);
      if (!pick_found && xq_valid[cand]) begin
        pick_found = 1'b1;
        pick_id    = cand;
      end
    end
  end

  // First byte leaves in the pick cycle, no bubble
  // Mid-frame the source being served is the last one picked
  always_comb begin
    sel_id = (state == PICK) ? pick_id : last_q;
    pop    = ((state == PICK) && pick_found) || ((state == SEND) && xq_valid[last_q]);
    xq_ready         = '0;
    xq_ready[sel_id] = pop;
  end

  // --------------------
  // Transmit register
  // --------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= PICK;
      last_q  <= '1;
      gap_cnt <= '0;
      gmii_tx <= '0;
    end else begin
      gmii_tx.en <= 1'b0;
      if (pop) begin
        gmii_tx.en   <= 1'b1;
        gmii_tx.data <= xq_data[sel_id].data;
        last_q       <= sel_id;
        gap_cnt      <= '0;
        if (xq_data[sel_id].last) begin
          state <= GAP;
        end else begin
          state <= SEND;
        end
      end else if (state == GAP) begin
        // en stays low for exactly IFG_CYCLES cycles
        if (gap_cnt == GAP_LAST) begin
          state <= PICK;
        end else begin
          gap_cnt <= gap_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/switch_macros.svh ====
// Sizing macros shared by the switch package and every RTL module
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// --------------------
// Ports and byte lane
// --------------------
`define NPORT 4
`define BYTE_W 8

// --------------------
// Queue sizes
// --------------------
// Address widths, 128 words each
`define RXQ_DEPTH_LOG2 7
`define XQ_DEPTH_LOG2 7

// Idle cycles on transmit after every frame
`define IFG_CYCLES 12

`endif

// ==== logic/switch_pkg.sv ====
// Shared switch datapath types imported by the RTL modules
`include "switch_macros.svh"

package switch_pkg;

  typedef logic [`BYTE_W-1:0] byte_t;
  typedef logic [1:0]         port_id_t;
  typedef logic [`NPORT-1:0]  port_mask_t;

  // One GMII lane, en is rx_dv or tx_en
  typedef struct packed {
    logic  en;
    byte_t data;
  } gmii_t;

  // Crossbar queue entry
  typedef struct packed {
    logic  last;
    byte_t data;
  } xq_word_t;

  // Receive queue entry with the frame's destinations
  typedef struct packed {
    port_mask_t mask;
    xq_word_t   word;
  } rx_word_t;

  // --------------------
  // FSM states
  // --------------------
  typedef enum logic {IDLE, FRAME} rx_state_e;

  typedef enum logic {HEAD, BODY} fwd_state_e;

  typedef enum logic [1:0] {PICK, SEND, GAP} mix_state_e;

endpackage
